// ==== rtl/pref_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predictor index_width must not exceed hist_idx_width
// learned strides are kept as 8-bit signed line counts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pref_pkg;

    localparam int addr_width     = 32;
    localparam int line_offset    = 5;
    localparam int line_width     = addr_width - line_offset;
    localparam int conf_width     = 2;
    localparam int stat_width     = 16;
    localparam int stride_width   = 8;
    localparam int hist_idx_width = 6;

    localparam logic [conf_width-1:0] conf_init   = conf_width'(2);
    localparam logic [conf_width-1:0] conf_thresh = conf_width'(2);
    localparam logic [conf_width-1:0] conf_max    = '1;

    typedef enum logic {
        inst = 1'b0,
        data = 1'b1
    } pref_type_e;

    typedef struct packed {
        logic [7:0]                pad;
        logic [conf_width-1:0]     conf;
        logic [hist_idx_width-1:0] idx;
    } inst_hist_t;

    typedef struct packed {
        logic [hist_idx_width-1:0]      idx;
        logic [conf_width-1:0]          conf;
        logic signed [stride_width-1:0] stride;
    } data_hist_t;

    // same 16-bit word, decoded by whichever predictor made the request
    typedef union packed {
        inst_hist_t ih;
        data_hist_t dh;
    } pref_hist_u;

    typedef struct packed {
        logic [line_width-1:0] line;
        pref_hist_u            hist;
    } pref_cand_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        pref_type_e            ptype;
    } pref_req_t;

    typedef struct packed {
        logic complete;
        logic hit;
        logic miss;
    } pref_resp_t;

    typedef struct packed {
        logic       en;
        logic       useful;
        pref_hist_u hist;
    } pref_train_t;

    typedef struct packed {
        logic [stat_width-1:0] total;
        logic [stat_width-1:0] hit;
        logic [stat_width-1:0] miss;
        logic [stat_width-1:0] anneal;
    } pref_stats_t;

    // 2-bit saturating confidence step
    function automatic logic [conf_width-1:0] conf_next(
        input logic [conf_width-1:0] conf,
        input logic                  up
    );
        logic [conf_width-1:0] res;
        res = conf;
        if (up && conf != conf_max) begin
            res = conf + 1'b1;
        end else if (!up && conf != '0) begin
            res = conf - 1'b1;
        end
        return res;
    endfunction

endpackage

// ==== rtl/pref_issue_fsm.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one prefetch outstanding at a time, no candidate queue
// L2 must return exactly one complete pulse per accepted request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pref_issue_fsm (
    input  logic                  clk,
    input  logic                  rstn,
    input  pref_pkg::pref_cand_t  inst_cand,
    input  logic                  inst_cand_valid,
    output logic                  inst_cand_ready,
    input  pref_pkg::pref_cand_t  data_cand,
    input  logic                  data_cand_valid,
    output logic                  data_cand_ready,
    output pref_pkg::pref_req_t   l2_req,
    output logic                  l2_req_valid,
    input  logic                  l2_req_ready,
    input  pref_pkg::pref_resp_t  l2_resp,
    output pref_pkg::pref_train_t inst_train,
    output pref_pkg::pref_train_t data_train
);
    import pref_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } state_e;

    state_e                state;
    logic [line_width-1:0] req_line;
    pref_type_e            req_type;
    pref_hist_u            req_hist;
    logic                  train_en;
    logic                  train_useful;

    // data candidate wins over instruction
    assign data_cand_ready = (state == IDLE) && data_cand_valid;
    assign inst_cand_ready = (state == IDLE) && inst_cand_valid && !data_cand_valid;

    assign l2_req_valid = (state == REQ);
    assign l2_req       = '{addr: {req_line, {line_offset{1'b0}}}, ptype: req_type};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            train_en <= 1'b0;
        end else begin
            train_en <= 1'b0;
            case (state)
                IDLE: begin
                    if (data_cand_ready || inst_cand_ready) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (l2_req_ready) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (l2_resp.complete) begin
                        state    <= IDLE;
                        train_en <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latched request and its history record
    always_ff @(posedge clk) begin
        if (data_cand_ready) begin
            req_line <= data_cand.line;
            req_type <= data;
            req_hist <= data_cand.hist;
        end else if (inst_cand_ready) begin
            req_line <= inst_cand.line;
            req_type <= inst;
            req_hist <= inst_cand.hist;
        end
        // a miss means the line was fetched, so the prefetch paid off
        if (state == WAIT && l2_resp.complete) begin
            train_useful <= l2_resp.miss;
        end
    end

    assign inst_train = '{en: train_en && (req_type == inst), useful: train_useful,
                          hist: req_hist};
    assign data_train = '{en: train_en && (req_type == data), useful: train_useful,
                          hist: req_hist};

endmodule

// ==== rtl/pref_stat_counter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// counters stick at their maximum and clear only on reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pref_stat_counter (
    input  logic                 clk,
    input  logic                 rstn,
    input  pref_pkg::pref_resp_t l2_resp,
    input  logic                 anneal_unhit,
    output pref_pkg::pref_stats_t stats
);
    import pref_pkg::*;

    logic hit_ev;
    logic miss_ev;

    function automatic logic [stat_width-1:0] sat_inc(
        input logic [stat_width-1:0] cnt,
        input logic                  ev
    );
        logic [stat_width-1:0] res;
        res = cnt;
        if (ev && cnt != '1) begin
            res = cnt + 1'b1;
        end
        return res;
    endfunction

    assign hit_ev  = l2_resp.complete && l2_resp.hit;
    assign miss_ev = l2_resp.complete && l2_resp.miss;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stats <= '0;
        end else begin
            stats.total  <= sat_inc(stats.total, l2_resp.complete);
            stats.hit    <= sat_inc(stats.hit, hit_ev);
            stats.miss   <= sat_inc(stats.miss, miss_ev);
            stats.anneal <= sat_inc(stats.anneal, anneal_unhit);
        end
    end

endmodule

// ==== rtl/inst_pred.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table index is the low line bits, aliasing lines share an entry
// a dropped candidate lets the same fetch line predict again
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module inst_pred #(
    parameter int index_width = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [pref_pkg::line_width-1:0] fetch_line,
    input  logic                            fetch_valid,
    output pref_pkg::pref_cand_t            cand,
    output logic                            cand_valid,
    input  logic                            cand_ready,
    input  pref_pkg::pref_train_t           train,
    input  logic                            anneal_unhit,
    input  pref_pkg::pref_type_e            anneal_type,
    input  logic [pref_pkg::addr_width-1:0] anneal_addr
);
    import pref_pkg::*;

    localparam int entries = 2 ** index_width;

    logic [conf_width-1:0]  conf_tab [entries];
    logic [line_width-1:0]  prev_line;
    logic                   prev_valid;
    logic [line_width-1:0]  next_line;
    logic [index_width-1:0] next_idx;
    logic [index_width-1:0] train_idx;
    logic [index_width-1:0] anneal_idx;
    logic                   new_line;
    pref_hist_u             hist_word;

    assign next_line  = fetch_line + 1'b1;
    assign next_idx   = next_line[index_width-1:0];
    assign train_idx  = train.hist.ih.idx[index_width-1:0];
    assign anneal_idx = anneal_addr[line_offset +: index_width];
    assign new_line   = fetch_valid && (!prev_valid || fetch_line != prev_line);

    always_comb begin
        hist_word         = '0;
        hist_word.ih.idx  = hist_idx_width'(next_idx);
        hist_word.ih.conf = conf_tab[next_idx];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prev_valid <= 1'b0;
            cand_valid <= 1'b0;
        end else begin
            cand_valid <= new_line && (conf_tab[next_idx] >= conf_thresh);
            if (fetch_valid) begin
                prev_valid <= 1'b1;
            end else if (cand_valid && !cand_ready) begin
                prev_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            prev_line <= fetch_line;
        end
        if (new_line) begin
            cand.line <= next_line;
            cand.hist <= hist_word;
        end
    end

    // anneal overrides training on the same entry
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                conf_tab[i] <= conf_init;
            end
        end else begin
            if (train.en) begin
                conf_tab[train_idx] <= conf_next(conf_tab[train_idx], train.useful);
            end
            if (anneal_unhit && anneal_type == inst) begin
                conf_tab[anneal_idx] <= '0;
            end
        end
    end

endmodule

// ==== rtl/data_pred.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// indexed by PC word address bits, strides limited to +/-127 lines
// the line last accepted by the issue machine is not offered again
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module data_pred #(
    parameter int index_width = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [pref_pkg::line_width-1:0] acc_line,
    input  logic [pref_pkg::addr_width-1:0] acc_pc,
    input  logic                            acc_valid,
    output pref_pkg::pref_cand_t            cand,
    output logic                            cand_valid,
    input  logic                            cand_ready,
    input  pref_pkg::pref_train_t           train,
    input  logic                            anneal_unhit,
    input  pref_pkg::pref_type_e            anneal_type,
    input  logic [pref_pkg::addr_width-1:0] anneal_addr
);
    import pref_pkg::*;

    localparam int entries = 2 ** index_width;

    typedef struct packed {
        logic [line_width-1:0]          last_line;
        logic signed [stride_width-1:0] stride;
        logic [conf_width-1:0]          conf;
        logic                           valid;
    } stride_entry_t;

    stride_entry_t            tab [entries];
    stride_entry_t            ent;
    stride_entry_t            upd;
    logic [index_width-1:0]   pc_idx;
    logic [index_width-1:0]   train_idx;
    logic [index_width-1:0]   anneal_idx;
    logic [line_width-1:0]    delta;
    logic [stride_width-1:0]  new_stride;
    logic [line_width-1:0]    target;
    logic [line_width-1:0]    issued_line;
    logic                     issued_valid;
    logic                     offer;
    pref_hist_u               hist_word;

    // the two byte bits of the word-aligned PC are skipped
    assign pc_idx     = acc_pc[2 +: index_width];
    assign train_idx  = train.hist.dh.idx[index_width-1:0];
    assign anneal_idx = anneal_addr[2 +: index_width];
    assign ent        = tab[pc_idx];
    assign delta      = acc_line - ent.last_line;
    assign new_stride = delta[stride_width-1:0];

    always_comb begin
        upd           = ent;
        upd.last_line = acc_line;
        upd.valid     = 1'b1;
        if (!ent.valid) begin
            upd.stride = '0;
        end else if (new_stride == ent.stride) begin
            upd.conf = conf_next(ent.conf, 1'b1);
        end else begin
            upd.conf = conf_next(ent.conf, 1'b0);
            // stride 0 means nothing learned yet
            if (upd.conf == '0 || ent.stride == '0) begin
                upd.stride = new_stride;
            end
        end
    end

    assign target = acc_line + {{(line_width - stride_width){upd.stride[stride_width-1]}},
                                upd.stride};
    assign offer  = acc_valid && (upd.conf >= conf_thresh) && (upd.stride != '0)
                    && !(issued_valid && target == issued_line);

    always_comb begin
        hist_word           = '0;
        hist_word.dh.idx    = hist_idx_width'(pc_idx);
        hist_word.dh.conf   = upd.conf;
        hist_word.dh.stride = upd.stride;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cand_valid   <= 1'b0;
            issued_valid <= 1'b0;
        end else begin
            cand_valid <= offer;
            if (cand_valid && cand_ready) begin
                issued_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (offer) begin
            cand.line <= target;
            cand.hist <= hist_word;
        end
        if (cand_valid && cand_ready) begin
            issued_line <= cand.line;
        end
    end

    // training overrides the access write and anneal overrides both
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                tab[i] <= '{last_line: '0, stride: '0, conf: conf_init, valid: 1'b0};
            end
        end else begin
            if (acc_valid) begin
                tab[pc_idx] <= upd;
            end
            if (train.en) begin
                tab[train_idx].conf <= conf_next(tab[train_idx].conf, train.useful);
            end
            if (anneal_unhit && anneal_type == data) begin
                tab[anneal_idx].conf <= '0;
            end
        end
    end

endmodule

// ==== rtl/prefetching.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// index_width sets both predictor tables and may be at most 6
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module prefetching #(
    parameter int index_width = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [pref_pkg::line_width-1:0] fetch_line,
    input  logic                            fetch_valid,
    input  logic [pref_pkg::line_width-1:0] acc_line,
    input  logic [pref_pkg::addr_width-1:0] acc_pc,
    input  logic                            acc_valid,
    input  logic                            anneal_unhit,
    input  pref_pkg::pref_type_e            anneal_type,
    input  logic [pref_pkg::addr_width-1:0] anneal_addr,
    output pref_pkg::pref_req_t             l2_req,
    output logic                            l2_req_valid,
    input  logic                            l2_req_ready,
    input  pref_pkg::pref_resp_t            l2_resp,
    output pref_pkg::pref_stats_t           stats
);
    import pref_pkg::*;

    pref_cand_t  inst_cand;
    logic        inst_cand_valid;
    logic        inst_cand_ready;
    pref_cand_t  data_cand;
    logic        data_cand_valid;
    logic        data_cand_ready;
    pref_train_t inst_train;
    pref_train_t data_train;

    inst_pred #(
        .index_width(index_width)
    ) u_inst_pred (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_line  (fetch_line),
        .fetch_valid (fetch_valid),
        .cand        (inst_cand),
        .cand_valid  (inst_cand_valid),
        .cand_ready  (inst_cand_ready),
        .train       (inst_train),
        .anneal_unhit(anneal_unhit),
        .anneal_type (anneal_type),
        .anneal_addr (anneal_addr)
    );

    data_pred #(
        .index_width(index_width)
    ) u_data_pred (
        .clk         (clk),
        .rstn        (rstn),
        .acc_line    (acc_line),
        .acc_pc      (acc_pc),
        .acc_valid   (acc_valid),
        .cand        (data_cand),
        .cand_valid  (data_cand_valid),
        .cand_ready  (data_cand_ready),
        .train       (data_train),
        .anneal_unhit(anneal_unhit),
        .anneal_type (anneal_type),
        .anneal_addr (anneal_addr)
    );

    pref_issue_fsm u_issue_fsm (
        .clk            (clk),
        .rstn           (rstn),
        .inst_cand      (inst_cand),
        .inst_cand_valid(inst_cand_valid),
        .inst_cand_ready(inst_cand_ready),
        .data_cand      (data_cand),
        .data_cand_valid(data_cand_valid),
        .data_cand_ready(data_cand_ready),
        .l2_req         (l2_req),
        .l2_req_valid   (l2_req_valid),
        .l2_req_ready   (l2_req_ready),
        .l2_resp        (l2_resp),
        .inst_train     (inst_train),
        .data_train     (data_train)
    );

    pref_stat_counter u_stat_counter (
        .clk         (clk),
        .rstn        (rstn),
        .l2_resp     (l2_resp),
        .anneal_unhit(anneal_unhit),
        .stats       (stats)
    );

endmodule

// ==== sim/tb_prefetching.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reads steps and expected results from sim/pref_input.txt below the project root
// the L2 model serves one request at a time and the run stops at the first error
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_prefetching;
    import pref_pkg::*;

    localparam int req_latency     = 2;
    localparam int req_latency_max = 8;
    localparam int watch_cycles    = 4;
    localparam int resp_delay_max  = 64;

    logic                  clk;
    logic                  rstn;
    logic [line_width-1:0] fetch_line;
    logic                  fetch_valid;
    logic [line_width-1:0] acc_line;
    logic [addr_width-1:0] acc_pc;
    logic                  acc_valid;
    logic                  anneal_unhit;
    pref_type_e            anneal_type;
    logic [addr_width-1:0] anneal_addr;
    pref_req_t             l2_req;
    logic                  l2_req_valid;
    logic                  l2_req_ready;
    pref_resp_t            l2_resp;
    pref_stats_t           stats;

    integer           seed;
    integer           fd;
    integer           code;
    int               steps;
    logic [63:0]      kind;
    logic [8*256-1:0] rest;

    // fields of one input line
    logic [31:0] fv;
    logic [31:0] fline;
    logic [31:0] av;
    logic [31:0] aline;
    logic [31:0] apc;
    logic [31:0] exp_req;
    logic [31:0] eaddr;
    logic [31:0] etype;
    logic [31:0] delay;
    logic [31:0] resp_kind;
    logic [31:0] ann;
    logic [31:0] atype;
    logic [31:0] aaddr;

    logic        outstanding;
    pref_req_t   held_req;
    pref_stats_t exp_stats;

    prefetching #(
        .index_width(4)
    ) DUT (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_line  (fetch_line),
        .fetch_valid (fetch_valid),
        .acc_line    (acc_line),
        .acc_pc      (acc_pc),
        .acc_valid   (acc_valid),
        .anneal_unhit(anneal_unhit),
        .anneal_type (anneal_type),
        .anneal_addr (anneal_addr),
        .l2_req      (l2_req),
        .l2_req_valid(l2_req_valid),
        .l2_req_ready(l2_req_ready),
        .l2_resp     (l2_resp),
        .stats       (stats)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_req(input pref_req_t got, input pref_req_t want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED l2_req: got addr %h type %h, expected addr %h type %h",
                                got.addr, got.ptype, want.addr, want.ptype));
        end
    endtask

    task automatic check_stats(input pref_stats_t got, input pref_stats_t want);
        if (got !== want) begin
            abort_run($sformatf({"CHECK FAILED stats: got total %h hit %h miss %h anneal %h, ",
                                 "expected total %h hit %h miss %h anneal %h"},
                                got.total, got.hit, got.miss, got.anneal,
                                want.total, want.hit, want.miss, want.anneal));
        end
    endtask

    task automatic wait_for_request(input pref_req_t want);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < req_latency_max) begin
            @(negedge clk);
            seen = l2_req_valid;
            n++;
        end
        if (!seen) begin
            abort_run("timeout: no L2 prefetch request appeared after the access");
        end
        if (n != req_latency) begin
            abort_run($sformatf("the L2 request appeared %0d cycles after the access, not %0d",
                                n, req_latency));
        end
        check_req(l2_req, want);
        held_req    = want;
        outstanding = 1'b1;
    endtask

    // a held request must stay put, an idle machine must stay quiet
    task automatic watch_no_request();
        repeat (watch_cycles) begin
            @(negedge clk);
            if (outstanding) begin
                check_flag("l2_req_valid", l2_req_valid, 1'b1);
                check_req(l2_req, held_req);
            end else begin
                check_flag("l2_req_valid", l2_req_valid, 1'b0);
            end
        end
    endtask

    task automatic run_access_step();
        pref_req_t want;
        want.addr  = eaddr;
        want.ptype = pref_type_e'(etype[0]);
        if (exp_req[0] && outstanding) begin
            abort_run("input file expects a new request while one is still outstanding");
        end
        @(posedge clk);
        fetch_valid <= fv[0];
        fetch_line  <= fline[line_width-1:0];
        acc_valid   <= av[0];
        acc_line    <= aline[line_width-1:0];
        acc_pc      <= apc;
        @(posedge clk);
        fetch_valid <= 1'b0;
        acc_valid   <= 1'b0;
        if (exp_req[0]) begin
            wait_for_request(want);
        end else begin
            watch_no_request();
        end
    endtask

    // behavioral L2 with random back-pressure, then completion after the given delay
    task automatic serve_request(input int resp_delay, input logic is_hit);
        int   hold;
        int   n;
        logic taken;
        hold  = {$random(seed)} % 4;
        n     = 0;
        taken = 1'b0;
        repeat (hold) @(posedge clk);
        @(posedge clk);
        l2_req_ready <= 1'b1;
        while (!taken && n < req_latency_max) begin
            @(negedge clk);
            taken = l2_req_valid && l2_req_ready;
            n++;
        end
        if (!taken) begin
            abort_run("timeout: the L2 request was never accepted");
        end
        @(posedge clk);
        l2_req_ready <= 1'b0;
        repeat (resp_delay) @(posedge clk);
        @(posedge clk);
        l2_resp.complete <= 1'b1;
        l2_resp.hit      <= is_hit;
        l2_resp.miss     <= !is_hit;
        @(posedge clk);
        l2_resp     <= '0;
        outstanding = 1'b0;
        exp_stats.total = exp_stats.total + 1'b1;
        if (is_hit) begin
            exp_stats.hit = exp_stats.hit + 1'b1;
        end else begin
            exp_stats.miss = exp_stats.miss + 1'b1;
        end
        @(negedge clk);
        check_stats(stats, exp_stats);
        check_flag("l2_req_valid", l2_req_valid, 1'b0);
    endtask

    task automatic pulse_anneal(input logic ann_type, input logic [addr_width-1:0] ann_addr);
        @(posedge clk);
        anneal_unhit <= 1'b1;
        anneal_type  <= pref_type_e'(ann_type);
        anneal_addr  <= ann_addr;
        @(posedge clk);
        anneal_unhit <= 1'b0;
        exp_stats.anneal = exp_stats.anneal + 1'b1;
        @(negedge clk);
        check_stats(stats, exp_stats);
    endtask

    task automatic run_l2_step();
        if (resp_kind != 0) begin
            if (!outstanding) begin
                abort_run("L2 step in the input file has no outstanding request to serve");
            end
            if (delay > resp_delay_max) begin
                abort_run("L2 step in the input file has a completion delay that is too long");
            end
            serve_request(delay, resp_kind == 1);
        end
        if (ann[0]) begin
            pulse_anneal(atype[0], aaddr);
        end
    endtask

    initial begin
        seed         = 36384;
        steps        = 0;
        outstanding  = 1'b0;
        held_req     = '0;
        exp_stats    = '0;
        rstn         = 1'b0;
        fetch_line   = '0;
        fetch_valid  = 1'b0;
        acc_line     = '0;
        acc_pc       = '0;
        acc_valid    = 1'b0;
        anneal_unhit = 1'b0;
        anneal_type  = inst;
        anneal_addr  = '0;
        l2_req_ready = 1'b0;
        l2_resp      = '0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag("l2_req_valid", l2_req_valid, 1'b0);
        check_stats(stats, exp_stats);

        fd = $fopen("sim/pref_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the input file sim/pref_input.txt");
        end
        code = $fscanf(fd, "%s", kind);
        while (code == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "A") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                               fv, fline, av, aline, apc, exp_req, eaddr, etype);
                if (code != 8) begin
                    abort_run("malformed access step in the input file");
                end
                run_access_step();
                steps++;
            end else if (kind == "L") begin
                code = $fscanf(fd, "%h %h %h %h %h", delay, resp_kind, ann, atype, aaddr);
                if (code != 5) begin
                    abort_run("malformed L2 step in the input file");
                end
                run_l2_step();
                steps++;
            end else begin
                abort_run("unknown step kind in the input file");
            end
            code = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);

        if (steps == 0) begin
            abort_run("no steps were read from the input file");
        end else if (outstanding) begin
            abort_run("input file ended with a prefetch request still outstanding");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== sim/pref_input.txt ====
# A fetch_valid fetch_line acc_valid acc_line acc_pc expect_req req_addr req_type
# L resp_delay resp (0 none, 1 hit, 2 miss) anneal anneal_type anneal_addr
# next-line fetch, then the same line again
A 1 100 0 0 0 1 2020 0
L 2 2 0 0 0
A 1 100 0 0 0 0 0 0
# index 1 raised by a miss, then lowered by hits
A 1 110 0 0 0 1 2220 0
L 1 1 0 0 0
A 1 100 0 0 0 1 2020 0
L 0 1 0 0 0
A 1 110 0 0 0 0 0 0
A 1 100 0 0 0 0 0 0
# constant stride of 4 lines on pc 1000
A 0 0 1 400 1000 0 0 0
A 0 0 1 404 1000 0 0 0
A 0 0 1 408 1000 1 8180 1
L 3 2 0 0 0
# irregular strides on pc 1004
A 0 0 1 500 1004 0 0 0
A 0 0 1 503 1004 0 0 0
A 0 0 1 505 1004 0 0 0
A 0 0 1 50c 1004 0 0 0
# data wins over instruction, later candidates dropped while busy
A 1 123 1 40c 1000 1 8200 1
A 1 133 0 0 0 0 0 0
A 0 0 1 410 1000 0 0 0
L 1 1 0 0 0
A 0 0 0 0 0 0 0 0
# anneal an instruction entry that was in use
A 1 1f4 0 0 0 1 3ea0 0
L 2 2 0 0 0
L 0 0 1 0 a0
A 1 204 0 0 0 0 0 0
# anneal the stride entry, it relearns on the next accesses
L 0 0 1 1 1000
A 0 0 1 414 1000 0 0 0
A 0 0 1 418 1000 1 8380 1
L 2 2 1 0 a0
A 0 0 0 0 0 0 0 0

// ==== tb.f ====
rtl/pref_pkg.sv
rtl/pref_issue_fsm.sv
rtl/pref_stat_counter.sv
rtl/inst_pred.sv
rtl/data_pred.sv
rtl/prefetching.sv
sim/tb_prefetching.sv

// ==== Bender.yml ====
package:
  name: prefetching

sources:
  - files:
      - rtl/pref_pkg.sv
      - rtl/pref_issue_fsm.sv
      - rtl/pref_stat_counter.sv
      - rtl/inst_pred.sv
      - rtl/data_pred.sv
      - rtl/prefetching.sv
  - target: simulation
    files:
      - sim/tb_prefetching.sv
